//--- motor_regs_pkg.sv
// ##########################################################################
// Motor register map package
// Bus widths, address map, field positions and register types
// ##########################################################################
package motor_regs_pkg;

    // Bus and field widths
    localparam int ADDR_W       = 6;
    localparam int DATA_W       = 8;
    localparam int ANGLE_W      = 12;   // Full rotation angle
    localparam int DRIVE_TEMP_W = 7;
    localparam int ROT_TEMP_W   = 6;
    localparam int PWM_W        = 5;

    // Channel counts
    localparam int N_DRIVE = 4;
    localparam int N_ROT   = 4;

    typedef logic [ADDR_W-1:0]  reg_addr_t;
    typedef logic [DATA_W-1:0]  reg_data_t;
    typedef logic [ANGLE_W-1:0] angle_t;

    // Broadcast writes, 0x00 reserved
    localparam reg_addr_t ADDR_BCAST_ALL   = 6'h01;   // Every control register
    localparam reg_addr_t ADDR_BCAST_ROT   = 6'h02;   // Rotation controls only
    localparam reg_addr_t ADDR_BCAST_DRIVE = 6'h03;   // Drive controls only

    // Drive channels, control then status
    localparam reg_addr_t DRIVE_BASE   = 6'h04;
    localparam int        DRIVE_STRIDE = 2;

    // Rotation channels, five registers each
    localparam reg_addr_t ROT_BASE       = 6'h0C;
    localparam int        ROT_STRIDE     = 5;
    localparam int        ROT_OFS_CTRL   = 0;
    localparam int        ROT_OFS_STATUS = 1;
    localparam int        ROT_OFS_TARG   = 2;   // Target angle low byte
    localparam int        ROT_OFS_CURR   = 3;   // Current angle low byte
    localparam int        ROT_OFS_CMD    = 4;   // Pulses on write, done flag on read

    // Command register bits
    localparam int CMD_ABORT_BIT  = 4;
    localparam int CMD_UPDATE_BIT = 5;
    localparam int DONE_BIT       = 7;   // Arrival flag in readback

    // Drive control byte
    typedef struct packed {
        logic             brake;       // Bit 7
        logic             enable;
        logic             direction;
        logic [PWM_W-1:0] pwm;         // Bits 4..0
    } drive_ctrl_t;

    // Rotation control byte
    typedef struct packed {
        logic       brake;             // Bit 7
        logic       enable;
        logic       direction;
        logic       spare;             // Stored, no function
        logic [3:0] target_hi;         // Target angle bits 11..8
    } rot_ctrl_t;

endpackage

//--- reg_bus_if.sv
// ##########################################################################
// Host register bus
// Address, write strobe and data, plus the read strobe
// ##########################################################################
interface reg_bus_if;

    motor_regs_pkg::reg_addr_t address;    // Shared by reads and writes
    logic                      write_en;   // One write per high cycle
    motor_regs_pkg::reg_data_t wr_data;
    logic                      read_en;    // Captures read data

    // Channel register blocks decode writes and reads
    modport regs (
        input address,
        input write_en,
        input wr_data
    );

    // Read data capture only needs the strobe
    modport reader (
        input read_en
    );

endinterface

//--- drive_channel_regs.sv
// ##########################################################################
// Drive motor channel registers
// Control byte with broadcast writes and a status byte sampled every clock
// ##########################################################################
module drive_channel_regs #(
    parameter int CHANNEL = 0   // Drive channel index
) (
    input  logic                                    clock,
    input  logic                                    rst_n,
    reg_bus_if.regs                                 bus,
    input  logic                                    fault,      // Motor driver fault
    input  logic [motor_regs_pkg::DRIVE_TEMP_W-1:0] adc_temp,
    output motor_regs_pkg::drive_ctrl_t             ctrl,
    output motor_regs_pkg::reg_data_t               rd_word     // Zero outside our range
);

    // Channel addresses
    localparam motor_regs_pkg::reg_addr_t CTRL_ADDR = motor_regs_pkg::reg_addr_t'(
        motor_regs_pkg::DRIVE_BASE + CHANNEL * motor_regs_pkg::DRIVE_STRIDE);
    localparam motor_regs_pkg::reg_addr_t STATUS_ADDR = motor_regs_pkg::reg_addr_t'(
        CTRL_ADDR + 1);

    motor_regs_pkg::reg_data_t status;   // {fault, temp}
    logic                      ctrl_wr;

    // Own address or either drive broadcast
    assign ctrl_wr = bus.write_en &&
                     (bus.address == CTRL_ADDR ||
                      bus.address == motor_regs_pkg::ADDR_BCAST_ALL ||
                      bus.address == motor_regs_pkg::ADDR_BCAST_DRIVE);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl <= '0;   // Motor off, brake released
        end else if (ctrl_wr) begin
            ctrl <= motor_regs_pkg::drive_ctrl_t'(bus.wr_data);
        end
    end

    // Status follows the motor one clock late
    always_ff @(posedge clock) begin
        status <= {fault, adc_temp};
    end

    always_comb begin
        if (bus.address == CTRL_ADDR)
            rd_word = motor_regs_pkg::reg_data_t'(ctrl);
        else if (bus.address == STATUS_ADDR)
            rd_word = status;
        else
            rd_word = '0;
    end

endmodule

//--- rotation_channel_regs.sv
// ##########################################################################
// Rotation motor channel registers
// Control, status, target and current angle, command pulses
// ##########################################################################
module rotation_channel_regs #(
    parameter int CHANNEL = 0   // Rotation channel index
) (
    input  logic                                  clock,
    input  logic                                  rst_n,
    reg_bus_if.regs                               bus,
    input  logic                                  fault,
    input  logic                                  startup_fail,   // Stalled at startup
    input  logic [motor_regs_pkg::ROT_TEMP_W-1:0] adc_temp,
    input  motor_regs_pkg::angle_t                current_angle,
    input  logic                                  angle_done,     // Arrived at target
    output motor_regs_pkg::rot_ctrl_t             ctrl,
    output motor_regs_pkg::angle_t                target_angle,
    output logic                                  update_angle,   // Start rotation
    output logic                                  abort_angle,    // Stop rotation
    output motor_regs_pkg::reg_data_t             rd_word
);

    // First register of this channel
    localparam motor_regs_pkg::reg_addr_t BASE_ADDR = motor_regs_pkg::reg_addr_t'(
        motor_regs_pkg::ROT_BASE + CHANNEL * motor_regs_pkg::ROT_STRIDE);

    localparam motor_regs_pkg::reg_addr_t CTRL_ADDR =
        motor_regs_pkg::reg_addr_t'(BASE_ADDR + motor_regs_pkg::ROT_OFS_CTRL);
    localparam motor_regs_pkg::reg_addr_t STATUS_ADDR =
        motor_regs_pkg::reg_addr_t'(BASE_ADDR + motor_regs_pkg::ROT_OFS_STATUS);
    localparam motor_regs_pkg::reg_addr_t TARG_ADDR =
        motor_regs_pkg::reg_addr_t'(BASE_ADDR + motor_regs_pkg::ROT_OFS_TARG);
    localparam motor_regs_pkg::reg_addr_t CURR_ADDR =
        motor_regs_pkg::reg_addr_t'(BASE_ADDR + motor_regs_pkg::ROT_OFS_CURR);
    localparam motor_regs_pkg::reg_addr_t CMD_ADDR =
        motor_regs_pkg::reg_addr_t'(BASE_ADDR + motor_regs_pkg::ROT_OFS_CMD);

    motor_regs_pkg::reg_data_t targ_lo;      // Target angle bits 7..0
    motor_regs_pkg::reg_data_t status;       // {fault, startup fail, temp}
    motor_regs_pkg::reg_data_t curr_lo;      // Current angle bits 7..0
    motor_regs_pkg::reg_data_t cmd_stat;     // Done flag and angle high nibble
    motor_regs_pkg::reg_data_t cmd_sample;
    logic                      ctrl_wr;
    logic                      targ_wr;
    logic                      cmd_wr;

    assign ctrl_wr = bus.write_en &&
                     (bus.address == CTRL_ADDR ||
                      bus.address == motor_regs_pkg::ADDR_BCAST_ALL ||
                      bus.address == motor_regs_pkg::ADDR_BCAST_ROT);
    assign targ_wr = bus.write_en && bus.address == TARG_ADDR;   // No broadcast
    assign cmd_wr  = bus.write_en && bus.address == CMD_ADDR;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl    <= '0;
            targ_lo <= '0;
        end else begin
            if (ctrl_wr)
                ctrl <= motor_regs_pkg::rot_ctrl_t'(bus.wr_data);
            if (targ_wr)
                targ_lo <= bus.wr_data;
        end
    end

    // Pulses last exactly one clock per command write
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
        end else begin
            update_angle <= cmd_wr && bus.wr_data[motor_regs_pkg::CMD_UPDATE_BIT];
            abort_angle  <= cmd_wr && bus.wr_data[motor_regs_pkg::CMD_ABORT_BIT];
        end
    end

    always_comb begin
        cmd_sample                           = '0;   // Bits 6..4 read zero
        cmd_sample[motor_regs_pkg::DONE_BIT] = angle_done;
        cmd_sample[3:0]                      = current_angle[motor_regs_pkg::ANGLE_W-1:8];
    end

    // Readback from the motor, sampled every clock
    always_ff @(posedge clock) begin
        status   <= {fault, startup_fail, adc_temp};
        curr_lo  <= current_angle[7:0];
        cmd_stat <= cmd_sample;
    end

    assign target_angle = {ctrl.target_hi, targ_lo};

    always_comb begin
        case (bus.address)
            CTRL_ADDR:   rd_word = motor_regs_pkg::reg_data_t'(ctrl);
            STATUS_ADDR: rd_word = status;
            TARG_ADDR:   rd_word = targ_lo;
            CURR_ADDR:   rd_word = curr_lo;
            CMD_ADDR:    rd_word = cmd_stat;
            default:     rd_word = '0;   // Not ours
        endcase
    end

endmodule

//--- read_return.sv
// ##########################################################################
// Read data return
// Merges the channel read words and registers them on read enable
// ##########################################################################
module read_return (
    input  logic                      clock,
    input  logic                      rst_n,
    reg_bus_if.reader                 bus,
    input  motor_regs_pkg::reg_data_t drive_words [motor_regs_pkg::N_DRIVE],
    input  motor_regs_pkg::reg_data_t rot_words   [motor_regs_pkg::N_ROT],
    output motor_regs_pkg::reg_data_t rd_data
);

    motor_regs_pkg::reg_data_t merged;   // OR of all channel words

    // Ranges are disjoint so at most one word is nonzero
    always_comb begin
        merged = '0;
        for (int i = 0; i < motor_regs_pkg::N_DRIVE; i++) begin
            merged = merged | drive_words[i];
        end
        for (int i = 0; i < motor_regs_pkg::N_ROT; i++) begin
            merged = merged | rot_words[i];
        end
    end

    // Holds between reads
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= merged;
        end
    end

endmodule

//--- motor_reg_file.sv
// ##########################################################################
// Swerve drive register file
// Host bus to four drive and four rotation motor channels
// ##########################################################################
module motor_reg_file (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  motor_regs_pkg::reg_addr_t               address,
    input  logic                                    write_en,
    input  motor_regs_pkg::reg_data_t               wr_data,
    input  logic                                    read_en,
    output motor_regs_pkg::reg_data_t               rd_data,

    // Drive motors
    input  logic [motor_regs_pkg::N_DRIVE-1:0]      drive_fault,
    input  logic [motor_regs_pkg::DRIVE_TEMP_W-1:0] drive_temp [motor_regs_pkg::N_DRIVE],
    output logic [motor_regs_pkg::N_DRIVE-1:0]      drive_brake,
    output logic [motor_regs_pkg::N_DRIVE-1:0]      drive_enable,
    output logic [motor_regs_pkg::N_DRIVE-1:0]      drive_direction,
    output logic [motor_regs_pkg::PWM_W-1:0]        drive_pwm [motor_regs_pkg::N_DRIVE],

    // Rotation motors
    input  logic [motor_regs_pkg::N_ROT-1:0]        rot_fault,
    input  logic [motor_regs_pkg::N_ROT-1:0]        startup_fail,
    input  logic [motor_regs_pkg::ROT_TEMP_W-1:0]   rot_temp [motor_regs_pkg::N_ROT],
    input  motor_regs_pkg::angle_t                  current_angle [motor_regs_pkg::N_ROT],
    input  logic [motor_regs_pkg::N_ROT-1:0]        angle_done,
    output logic [motor_regs_pkg::N_ROT-1:0]        rot_brake,
    output logic [motor_regs_pkg::N_ROT-1:0]        rot_enable,
    output logic [motor_regs_pkg::N_ROT-1:0]        rot_direction,
    output motor_regs_pkg::angle_t                  target_angle [motor_regs_pkg::N_ROT],
    output logic [motor_regs_pkg::N_ROT-1:0]        update_angle,
    output logic [motor_regs_pkg::N_ROT-1:0]        abort_angle
);

    reg_bus_if bus ();

    motor_regs_pkg::drive_ctrl_t drive_ctrl  [motor_regs_pkg::N_DRIVE];
    motor_regs_pkg::rot_ctrl_t   rot_ctrl    [motor_regs_pkg::N_ROT];
    motor_regs_pkg::reg_data_t   drive_words [motor_regs_pkg::N_DRIVE];
    motor_regs_pkg::reg_data_t   rot_words   [motor_regs_pkg::N_ROT];

    // Host pins onto the internal bus
    assign bus.address  = address;
    assign bus.write_en = write_en;
    assign bus.wr_data  = wr_data;
    assign bus.read_en  = read_en;

    for (genvar d = 0; d < motor_regs_pkg::N_DRIVE; d++) begin : g_drive
        drive_channel_regs #(.CHANNEL(d)) u_drive (
            .clock    (clock),
            .rst_n    (rst_n),
            .bus      (bus.regs),
            .fault    (drive_fault[d]),
            .adc_temp (drive_temp[d]),
            .ctrl     (drive_ctrl[d]),
            .rd_word  (drive_words[d])
        );

        // Control fields out to the motor driver
        assign drive_brake[d]     = drive_ctrl[d].brake;
        assign drive_enable[d]    = drive_ctrl[d].enable;
        assign drive_direction[d] = drive_ctrl[d].direction;
        assign drive_pwm[d]       = drive_ctrl[d].pwm;
    end

    for (genvar r = 0; r < motor_regs_pkg::N_ROT; r++) begin : g_rot
        rotation_channel_regs #(.CHANNEL(r)) u_rot (
            .clock         (clock),
            .rst_n         (rst_n),
            .bus           (bus.regs),
            .fault         (rot_fault[r]),
            .startup_fail  (startup_fail[r]),
            .adc_temp      (rot_temp[r]),
            .current_angle (current_angle[r]),
            .angle_done    (angle_done[r]),
            .ctrl          (rot_ctrl[r]),
            .target_angle  (target_angle[r]),
            .update_angle  (update_angle[r]),
            .abort_angle   (abort_angle[r]),
            .rd_word       (rot_words[r])
        );

        assign rot_brake[r]     = rot_ctrl[r].brake;
        assign rot_enable[r]    = rot_ctrl[r].enable;
        assign rot_direction[r] = rot_ctrl[r].direction;   // Target nibble via target_angle
    end

    read_return u_read (
        .clock       (clock),
        .rst_n       (rst_n),
        .bus         (bus.reader),
        .drive_words (drive_words),
        .rot_words   (rot_words),
        .rd_data     (rd_data)
    );

endmodule

//--- tb_motor_reg_file.sv
// ##########################################################################
// Testbench for the swerve drive register file
// Table of writes, reads and output checks applied in a loop
// ##########################################################################
module tb_motor_reg_file;

    timeunit 1ns;
    timeprecision 1ps;

    localparam time CLK_PERIOD   = 40ns;
    localparam int  RESET_CYCLES = 5;

    typedef enum {OP_WR, OP_RD, OP_DRV, OP_ROT, OP_IDLE} op_e;

    typedef struct {
        op_e         op;
        logic [5:0]  addr;    // Bus address, or channel for output checks
        logic [7:0]  data;
        logic [31:0] stat;    // Status input pattern
        logic [15:0] exp;
        logic [7:0]  pulse;   // {update_angle, abort_angle} after the edge
    } row_t;

    logic                      clock;
    logic                      rst_n;
    motor_regs_pkg::reg_addr_t address;
    logic                      write_en;
    motor_regs_pkg::reg_data_t wr_data;
    logic                      read_en;
    motor_regs_pkg::reg_data_t rd_data;
    logic [3:0]                drive_fault;
    logic [6:0]                drive_temp [4];
    logic [3:0]                drive_brake;
    logic [3:0]                drive_enable;
    logic [3:0]                drive_direction;
    logic [4:0]                drive_pwm [4];
    logic [3:0]                rot_fault;
    logic [3:0]                startup_fail;
    logic [5:0]                rot_temp [4];
    motor_regs_pkg::angle_t    current_angle [4];
    logic [3:0]                angle_done;
    logic [3:0]                rot_brake;
    logic [3:0]                rot_enable;
    logic [3:0]                rot_direction;
    motor_regs_pkg::angle_t    target_angle [4];
    logic [3:0]                update_angle;
    logic [3:0]                abort_angle;

    row_t        rows [$];
    logic [7:0]  dctl [4];   // Expected drive control bytes
    logic [7:0]  rctl [4];   // Expected rotation control bytes
    logic [7:0]  targ [4];   // Expected target low bytes
    logic [31:0] cur_stat;
    bit          table_ready;

    motor_reg_file UUT (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Status inputs spread over the random pattern so each channel differs
    function automatic logic [6:0] drive_temp_of(input logic [31:0] s, input int i);
        return 7'(s >> (i * 5));
    endfunction

    function automatic logic [5:0] rot_temp_of(input logic [31:0] s, input int i);
        return 6'(s >> (i * 3 + 2));
    endfunction

    function automatic logic [11:0] angle_of(input logic [31:0] s, input int i);
        return 12'(s >> (i * 4 + 1));
    endfunction

    task automatic apply_status(input logic [31:0] s);
        for (int i = 0; i < 4; i++) begin
            drive_fault[i]   = s[16+i];
            drive_temp[i]    = drive_temp_of(s, i);
            rot_fault[i]     = s[20+i];
            startup_fail[i]  = s[24+i];
            rot_temp[i]      = rot_temp_of(s, i);
            current_angle[i] = angle_of(s, i);
            angle_done[i]    = s[28+i];
        end
    endtask

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s actual=%0h expected=%0h",
                     $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic add_row(input op_e op, input int addr, input logic [7:0] data,
                           input logic [15:0] exp, input logic [7:0] pulse);
        rows.push_back('{op, 6'(addr), data, cur_stat, exp, pulse});
    endtask

    // Outputs of all eight channels against the expected registers
    task automatic add_model_checks();
        for (int i = 0; i < 4; i++) begin
            add_row(OP_DRV, i, '0, 16'(dctl[i]), '0);
            add_row(OP_ROT, i, '0, {1'b0, rctl[i][7:5], rctl[i][3:0], targ[i]}, '0);
        end
    endtask

    task automatic build_table();
        logic [7:0] d;
        logic [7:0] p;
        logic [7:0] cmds [4];
        int         da;
        int         ra;
        cmds     = '{8'h20, 8'h10, 8'h30, 8'h0F};   // Update, abort, both, neither
        cur_stat = $urandom;
        for (int i = 0; i < 4; i++) begin
            dctl[i] = '0;
            rctl[i] = '0;
            targ[i] = '0;
        end
        add_model_checks();                     // Everything clear after reset
        add_row(OP_RD, 6'h04, '0, '0, '0);
        for (int i = 0; i < 4; i++) begin
            da = motor_regs_pkg::DRIVE_BASE + i * 2;
            d  = 8'($urandom);
            dctl[i] = d;
            add_row(OP_WR, da, d, '0, '0);
            add_row(OP_RD, da, '0, 16'(d), '0);
            add_model_checks();
        end
        for (int i = 0; i < 4; i++) begin
            ra = motor_regs_pkg::ROT_BASE + i * 5;
            rctl[i] = 8'($urandom);
            targ[i] = 8'($urandom);
            add_row(OP_WR, ra, rctl[i], '0, '0);
            add_row(OP_WR, ra + 2, targ[i], '0, '0);  // Target low byte
            add_row(OP_RD, ra, '0, 16'(rctl[i]), '0);
            add_row(OP_RD, ra + 2, '0, 16'(targ[i]), '0);
            add_model_checks();
        end
        add_row(OP_WR, 0, 8'($urandom), '0, '0);   // Reserved address is dropped
        add_model_checks();
        for (int b = 3; b >= 1; b--) begin          // Drive only, rotation only, all
            d = 8'($urandom);
            add_row(OP_WR, b, d, '0, '0);
            for (int i = 0; i < 4; i++) begin
                if (b != 2) dctl[i] = d;
                if (b != 3) rctl[i] = d;
            end
            add_model_checks();
        end
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                p       = '0;
                p[4+i]  = cmds[k][5];   // update_angle
                p[i]    = cmds[k][4];   // abort_angle
                add_row(OP_WR, motor_regs_pkg::ROT_BASE + i * 5 + 4, cmds[k], '0, p);
            end
        end
        add_row(OP_IDLE, 0, '0, '0, '0);
        cur_stat = $urandom;                          // New status held two cycles before reads
        add_row(OP_IDLE, 0, '0, '0, '0);
        for (int i = 0; i < 4; i++) begin
            da = motor_regs_pkg::DRIVE_BASE + i * 2 + 1;
            ra = motor_regs_pkg::ROT_BASE + i * 5;
            add_row(OP_RD, da, '0, 16'({cur_stat[16+i], drive_temp_of(cur_stat, i)}), '0);
            add_row(OP_RD, ra + 1, '0,
                    16'({cur_stat[20+i], cur_stat[24+i], rot_temp_of(cur_stat, i)}), '0);
            add_row(OP_RD, ra + 3, '0, 16'(angle_of(cur_stat, i) & 12'h0FF), '0);
            add_row(OP_RD, ra + 4, '0,
                    16'({cur_stat[28+i], 3'b000, 4'(angle_of(cur_stat, i) >> 8)}), '0);
        end
        add_row(OP_RD, 6'h30, '0, '0, '0);           // Unmapped
    endtask

    initial begin
        row_t r;
        int   c;
        void'($urandom(32'h19ca));
        rst_n    = 1'b0;
        address  = '0;
        write_en = 1'b0;
        wr_data  = '0;
        read_en  = 1'b0;
        apply_status('0);
        build_table();
        table_ready = 1'b1;
        apply_status(rows[0].stat);
        repeat (RESET_CYCLES) @(posedge clock);
        #2 rst_n = 1'b1;
        foreach (rows[k]) begin
            r        = rows[k];
            c        = int'(r.addr);
            apply_status(r.stat);
            address  = r.addr;
            wr_data  = r.data;
            write_en = (r.op == OP_WR);
            read_en  = (r.op == OP_RD);
            @(posedge clock);
            #1;                                     // Outputs settled after the edge
            check("{update_angle,abort_angle}", 16'({update_angle, abort_angle}), 16'(r.pulse));
            case (r.op)
                OP_RD:   check("rd_data", 16'(rd_data), r.exp);
                OP_DRV:  check($sformatf("drive[%0d] brake/enable/direction/pwm", c),
                               16'({drive_brake[c], drive_enable[c], drive_direction[c],
                                    drive_pwm[c]}), r.exp);
                OP_ROT:  check($sformatf("rot[%0d] brake/enable/direction/target_angle", c),
                               16'({rot_brake[c], rot_enable[c], rot_direction[c],
                                    target_angle[c]}), r.exp);
                default: ;
            endcase
            #1;                                     // Back to the drive point
        end
        $display("PASS: all tests");
        $finish;
    end

    // Four cycles per row plus reset and margin
    initial begin
        wait (table_ready);
        #((rows.size() * 4 + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("ERROR: timeout, the test table did not complete in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- src.f
motor_regs_pkg.sv
reg_bus_if.sv
drive_channel_regs.sv
rotation_channel_regs.sv
read_return.sv
motor_reg_file.sv
tb_motor_reg_file.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_motor_reg_file -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
run_status=$?
printf '%s\n' "$output"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^PASS: all tests$'; then
    exit 0
fi
echo "Pass message not found"
exit 1
